// ==== Makefile ====
# Verilator build and run for the calibrator testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_cal -f filelist.f -o Vtb_cal

run: compile
	@./obj_dir/Vtb_cal > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with an error"; exit 1; fi
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== cal_coeff_mem.sv ====
// Per-channel offset and gain registers.
// Reset loads the identity calibration: offset 0 and gain of unity.
// Reads are combinational, so the read address must be stable in its cycle.
// There is no read-back path to the configuration port.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_coeff_mem import cal_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      coeff_we,
    input  coeff_wr_t coeff_wr,
    input  chan_t     rd_ch,
    output coeff_t    offset,
    output coeff_t    gain
);

    // Unity gain in the fixed point format
    localparam coeff_t GAIN_UNITY = coeff_t'(1 << `CAL_FRAC_SHIFT);

    coeff_t offset_mem [`CAL_CHANNELS];
    coeff_t gain_mem   [`CAL_CHANNELS];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Every channel passes samples through unchanged until configured
            for (int i = 0; i < `CAL_CHANNELS; i++) begin
                offset_mem[i] <= '0;
                gain_mem[i]   <= GAIN_UNITY;
            end
        end else if (coeff_we) begin
            // One offset and gain pair per accepted write
            offset_mem[coeff_wr.ch] <= coeff_wr.offset;
            gain_mem[coeff_wr.ch]   <= coeff_wr.gain;
        end
    end

    // The sequencer reads the pair for the channel it issues this cycle
    assign offset = offset_mem[rd_ch];
    assign gain   = gain_mem[rd_ch];

endmodule

// ==== cal_ctrl.sv ====
// Calibrator sequencer.
// A frame starts only when one is captured and the output side is free.
// Channels issue in order 0 to 7, one per cycle, then the pipe drains.
// Configuration writes are accepted only in IDLE with no frame captured,
// so a frame never sees coefficients change part way through.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_ctrl import cal_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cap_full,
    input  frame_t    cap_frame,
    output logic      cap_release,
    input  coeff_wr_t cfg,
    input  logic      cfg_valid,
    output logic      cfg_ready,
    output logic      coeff_we,
    output coeff_wr_t coeff_wr,
    output chan_t     issue_ch,
    input  coeff_t    offset,
    input  coeff_t    gain,
    output mac_req_t  req,
    output logic      req_valid,
    input  logic      out_busy,
    output logic      frame_done
);

    // Must match the register depth of cal_mac_pipe
    localparam int MAC_LATENCY = 3;
    localparam chan_t LAST_CH  = chan_t'(`CAL_CHANNELS - 1);

    cal_state_t state;
    chan_t      issue_cnt;
    logic [1:0] drain_cnt;
    logic       live;

    // Selects the captured sample for one channel
    function automatic sample_t pick_lane(frame_t f, chan_t c);
        sample_t s;
        case (c)
            3'd0: s = f.ch0;
            3'd1: s = f.ch1;
            3'd2: s = f.ch2;
            3'd3: s = f.ch3;
            3'd4: s = f.ch4;
            3'd5: s = f.ch5;
            3'd6: s = f.ch6;
            default: s = f.ch7;
        endcase
        return s;
    endfunction

    // No frame anywhere in the datapath, and never on the cycle after reset
    assign cfg_ready = live && (state == IDLE) && !cap_full;
    assign coeff_we  = cfg_valid && cfg_ready;
    assign coeff_wr  = cfg;

    // The counter doubles as the memory read address and the pipeline tag
    assign issue_ch   = issue_cnt;
    assign req_valid  = (state == ISSUE);
    assign req.ch     = issue_cnt;
    assign req.sample = pick_lane(cap_frame, issue_cnt);
    assign req.offset = offset;
    assign req.gain   = gain;

    // The capture buffer is free once the last sample has been handed to the pipe
    assign cap_release = (state == ISSUE) && (issue_cnt == LAST_CH);
    // Channel 7 leaves the pipe on the cycle before this pulse
    assign frame_done  = (state == DRAIN) && (drain_cnt == 2'(MAC_LATENCY));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            issue_cnt <= '0;
            drain_cnt <= '0;
            live      <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                IDLE: begin
                    issue_cnt <= '0;
                    if (cap_full && !out_busy) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    issue_cnt <= issue_cnt + 1'b1;
                    drain_cnt <= '0;
                    if (issue_cnt == LAST_CH) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (frame_done) begin
                        state <= PRESENT;
                    end
                end
                PRESENT: begin
                    // Wait here while the output frame is still held
                    if (!out_busy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== cal_defs.svh ====
// Build-time constants shared by the calibrator RTL and its package.
// The channel index width is derived from CAL_CHANNELS, so keep it a power of two.
// Gains are signed fixed point with CAL_FRAC_SHIFT fraction bits.
// A gain of 1 << CAL_FRAC_SHIFT is unity.
`ifndef CAL_DEFS_SVH
`define CAL_DEFS_SVH

// Number of channels in one frame
`define CAL_CHANNELS 8

// Width of a sample and of each offset or gain coefficient
`define CAL_SAMPLE_W 16

// Fraction bits of the gain, so 1024 means a gain of exactly one
`define CAL_FRAC_SHIFT 10

`endif

// ==== cal_frame_assemble.sv ====
// Output frame builder.
// Each tagged result lands in its own lane; the frame is offered on frame_done.
// out_frame holds while out_valid is high, which relies on control not issuing
// a new frame until out_busy has fallen.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_frame_assemble import cal_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mac_res_t res,
    input  logic     res_valid,
    input  logic     frame_done,
    output frame_t   out_frame,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     out_busy
);

    logic handshake;

    assign handshake = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_busy  <= 1'b0;
        end else begin
            // Busy from the first result of a frame until the frame is taken
            if (handshake) begin
                out_busy <= 1'b0;
            end else if (res_valid) begin
                out_busy <= 1'b1;
            end
            if (handshake) begin
                out_valid <= 1'b0;
            end else if (frame_done) begin
                out_valid <= 1'b1;
            end
        end
    end

    // The tag picks the lane, so results may arrive in any order
    always_ff @(posedge clk) begin
        if (res_valid) begin
            case (res.ch)
                3'd0: out_frame.ch0 <= res.sample;
                3'd1: out_frame.ch1 <= res.sample;
                3'd2: out_frame.ch2 <= res.sample;
                3'd3: out_frame.ch3 <= res.sample;
                3'd4: out_frame.ch4 <= res.sample;
                3'd5: out_frame.ch5 <= res.sample;
                3'd6: out_frame.ch6 <= res.sample;
                3'd7: out_frame.ch7 <= res.sample;
            endcase
        end
    end

endmodule

// ==== cal_frame_capture.sv ====
// Single-entry input frame buffer.
// in_ready stays low on the first cycle after reset and whenever a frame is held.
// The source must hold in_frame and in_valid until the accepting edge.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_frame_capture import cal_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  frame_t in_frame,
    input  logic   in_valid,
    output logic   in_ready,
    input  logic   cap_release,
    output logic   cap_full,
    output frame_t cap_frame
);

    // Goes high one cycle after reset is released and stays there
    logic live;

    // A frame is taken only while the buffer is empty
    assign in_ready = live && !cap_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            live     <= 1'b0;
            cap_full <= 1'b0;
        end else begin
            live <= 1'b1;
            // Control releases the buffer on the cycle it issues the last channel
            // and a new frame cannot land on that same edge since in_ready is low
            if (cap_release) begin
                cap_full <= 1'b0;
            end else if (in_valid && in_ready) begin
                cap_full <= 1'b1;
            end
        end
    end

    // Payload register loads only on an accepted transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            cap_frame <= in_frame;
        end
    end

endmodule

// ==== cal_mac_pipe.sv ====
// Three-stage calibrate pipeline built around one shared multiplier.
// Latency is fixed at 3 cycles from req_valid to res_valid, with no stall.
// The shift truncates toward minus infinity; there is no rounding.
// Results outside the sample range clamp to the nearest limit.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_mac_pipe import cal_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mac_req_t req,
    input  logic     req_valid,
    output mac_res_t res,
    output logic     res_valid
);

    localparam int MSB = 2 * `CAL_SAMPLE_W;

    // Stage 1 holds the difference and the gain waiting for the multiplier
    diff_t  diff_s1;
    coeff_t gain_s1;
    chan_t  ch_s1;
    logic   valid_s1;

    // Stage 2 holds the full product
    prod_t  prod_s2;
    chan_t  ch_s2;
    logic   valid_s2;

    // Stage 3 inputs, formed combinationally from the product
    prod_t   shifted;
    logic    sat_hi;
    logic    sat_lo;
    sample_t clamped;

    // Valid bits are the only control state in the pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_s1  <= req_valid;
            valid_s2  <= valid_s1;
            res_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        // Both operands are sign extended by one bit so the subtraction is exact
        diff_s1 <= {req.sample[`CAL_SAMPLE_W-1], req.sample}
                 - {req.offset[`CAL_SAMPLE_W-1], req.offset};
        gain_s1 <= req.gain;
        ch_s1   <= req.ch;
        // Signed 17 by 16 product; this is the only multiplier in the design
        prod_s2 <= diff_s1 * gain_s1;
        ch_s2   <= ch_s1;
        res.ch     <= ch_s2;
        res.sample <= clamped;
    end

    always_comb begin
        shifted = prod_s2 >>> `CAL_FRAC_SHIFT;
        // The value fits in a sample only when all bits above the sample MSB
        // match the sign bit
        sat_hi  = !shifted[MSB] && (|shifted[MSB-1:`CAL_SAMPLE_W-1]);
        sat_lo  = shifted[MSB] && !(&shifted[MSB-1:`CAL_SAMPLE_W-1]);
        if (sat_hi) begin
            clamped = {1'b0, {(`CAL_SAMPLE_W-1){1'b1}}};
        end else if (sat_lo) begin
            clamped = {1'b1, {(`CAL_SAMPLE_W-1){1'b0}}};
        end else begin
            clamped = shifted[`CAL_SAMPLE_W-1:0];
        end
    end

endmodule

// ==== cal_pkg.sv ====
// Types shared by every calibrator block.
// Frame lanes are fixed at eight named fields and must track CAL_CHANNELS.
// Lane ch0 sits in the least significant bits of a packed frame.
`include "cal_defs.svh"

package cal_pkg;

    // One raw or calibrated sample, two's complement
    typedef logic signed [`CAL_SAMPLE_W-1:0] sample_t;

    // One offset or gain word, two's complement
    typedef logic signed [`CAL_SAMPLE_W-1:0] coeff_t;

    // Channel index, also used as the tag that travels down the pipeline
    typedef logic [$clog2(`CAL_CHANNELS)-1:0] chan_t;

    // Sample minus offset needs one extra bit so it can never wrap
    typedef logic signed [`CAL_SAMPLE_W:0] diff_t;

    // Full product of a difference and a gain
    typedef logic signed [2*`CAL_SAMPLE_W:0] prod_t;

    // One frame of eight samples, used for both input and output
    typedef struct packed {
        sample_t ch7;
        sample_t ch6;
        sample_t ch5;
        sample_t ch4;
        sample_t ch3;
        sample_t ch2;
        sample_t ch1;
        sample_t ch0;
    } frame_t;

    // One configuration write for a single channel
    typedef struct packed {
        chan_t  ch;
        coeff_t offset;
        coeff_t gain;
    } coeff_wr_t;

    // Everything the pipeline needs to calibrate one channel
    typedef struct packed {
        chan_t   ch;
        sample_t sample;
        coeff_t  offset;
        coeff_t  gain;
    } mac_req_t;

    // A tagged, saturated result leaving the pipeline
    typedef struct packed {
        chan_t   ch;
        sample_t sample;
    } mac_res_t;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        PRESENT
    } cal_state_t;

endpackage

// ==== cal_top.sv ====
// Eight-channel sample calibrator, top level.
// Output is clamp((in - offset) * gain >>> CAL_FRAC_SHIFT) per channel.
// With an empty output, out_valid rises 13 cycles after the input accept edge.
// All offsets reset to 0 and all gains to unity.
`timescale 1ns/1ps
`include "cal_defs.svh"

module cal_top import cal_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  frame_t    in_frame,
    input  logic      in_valid,
    output logic      in_ready,
    output frame_t    out_frame,
    output logic      out_valid,
    input  logic      out_ready,
    input  coeff_wr_t cfg,
    input  logic      cfg_valid,
    output logic      cfg_ready
);

    // Capture to control
    logic      cap_full;
    logic      cap_release;
    frame_t    cap_frame;

    // Control to coefficient memory and back
    logic      coeff_we;
    coeff_wr_t coeff_wr;
    chan_t     issue_ch;
    coeff_t    offset;
    coeff_t    gain;

    // Pipeline path
    mac_req_t  req;
    logic      req_valid;
    mac_res_t  res;
    logic      res_valid;

    // Assembler handshake with control
    logic      frame_done;
    logic      out_busy;

    cal_frame_capture i_capture (
        .clk         (clk),
        .rst         (rst),
        .in_frame    (in_frame),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .cap_release (cap_release),
        .cap_full    (cap_full),
        .cap_frame   (cap_frame)
    );

    cal_coeff_mem i_coeff_mem (
        .clk      (clk),
        .rst      (rst),
        .coeff_we (coeff_we),
        .coeff_wr (coeff_wr),
        .rd_ch    (issue_ch),
        .offset   (offset),
        .gain     (gain)
    );

    cal_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cap_full    (cap_full),
        .cap_frame   (cap_frame),
        .cap_release (cap_release),
        .cfg         (cfg),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .coeff_we    (coeff_we),
        .coeff_wr    (coeff_wr),
        .issue_ch    (issue_ch),
        .offset      (offset),
        .gain        (gain),
        .req         (req),
        .req_valid   (req_valid),
        .out_busy    (out_busy),
        .frame_done  (frame_done)
    );

    cal_mac_pipe i_mac_pipe (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .res       (res),
        .res_valid (res_valid)
    );

    cal_frame_assemble i_assemble (
        .clk        (clk),
        .rst        (rst),
        .res        (res),
        .res_valid  (res_valid),
        .frame_done (frame_done),
        .out_frame  (out_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_busy   (out_busy)
    );

endmodule

// ==== cal_trace.txt ====
# C ch offset gain | F in0..in7 exp0..exp7 stall | Q waits for an empty output
# All values hex; expected = clamp((in - offset) * gain >>> 10)
F 0000 0001 7fff 8000 1234 edcb 00ff ff00 0000 0001 7fff 8000 1234 edcb 00ff ff00 0
F 4000 c000 0400 fc00 7ffe 8001 0010 fff0 4000 c000 0400 fc00 7ffe 8001 0010 fff0 2
Q
C 0 0000 0200
C 1 0064 0400
C 2 ff9c 0800
C 3 0010 0300
C 4 0000 fc00
C 5 0100 0600
C 6 fff6 0100
C 7 0005 0400
F 03e8 0032 fed4 fff0 01f4 0064 fffe 0000 01f4 ffce fe70 ffe8 fe0c ff16 0002 fffb 0
F fffd 0065 ff9b 0011 fff9 0101 fff5 0005 fffe 0001 fffe 0000 0007 0001 ffff 0000 0
F 7fff 8000 7fff 8000 8000 7fff 8000 8000 3fff 8000 7fff 9ff4 7fff 7fff e002 8000 0
F 03e8 0032 fed4 fff0 01f4 0064 fffe 0000 01f4 ffce fe70 ffe8 fe0c ff16 0002 fffb 6
F fffd 0065 ff9b 0011 fff9 0101 fff5 0005 fffe 0001 fffe 0000 0007 0001 ffff 0000 0
F 7fff 8000 7fff 8000 8000 7fff 8000 8000 3fff 8000 7fff 9ff4 7fff 7fff e002 8000 3
Q
C 0 0000 0400
C 4 0000 0400
F 03e8 0032 fed4 fff0 01f4 0064 fffe 0000 03e8 ffce fe70 ffe8 01f4 ff16 0002 fffb 2
Q

// ==== filelist.f ====
+incdir+.
cal_pkg.sv
cal_frame_capture.sv
cal_coeff_mem.sv
cal_mac_pipe.sv
cal_frame_assemble.sv
cal_ctrl.sv
cal_top.sv
tb_cal.sv

// ==== tb_cal.sv ====
// Trace-driven testbench for the eight-channel calibrator.
// Reads cal_trace.txt from the directory the simulator runs in (the project root).
// Inputs are driven 2 ns after the rising edge; outputs are sampled on the edge.
// Every wait is bounded by WAIT_LIMIT cycles; a timeout ends the run as a failure.
`timescale 1ns/1ps
`include "cal_defs.svh"

module tb_cal import cal_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      rst;
    frame_t    in_frame;
    logic      in_valid;
    logic      in_ready;
    frame_t    out_frame;
    logic      out_valid;
    logic      out_ready;
    coeff_wr_t cfg;
    logic      cfg_valid;
    logic      cfg_ready;

    // Trace contents, one entry per record in file order
    byte       op_kind [$];
    coeff_wr_t cfg_list [$];
    frame_t    in_list [$];
    frame_t    exp_list [$];
    int        stall_list [$];

    // Accept cycle of each frame and whether its latency is checked
    int        acc_cyc [$];
    bit        lat_chk [$];

    int          cyc;
    int          n_acc;
    int          n_recv;
    int          value_errs;
    int          proto_errs;
    bit          abort;

    cal_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_frame  (in_frame),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_frame (out_frame),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Counts on the falling edge so readers on the rising edge see a settled value
    initial cyc = 0;
    always @(negedge clk) cyc = cyc + 1;

    task automatic check_sample(string name, sample_t exp, sample_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_frame(string name, frame_t exp, frame_t act);
        sample_t e;
        sample_t a;
        for (int i = 0; i < `CAL_CHANNELS; i++) begin
            e = exp[i*`CAL_SAMPLE_W +: `CAL_SAMPLE_W];
            a = act[i*`CAL_SAMPLE_W +: `CAL_SAMPLE_W];
            check_sample($sformatf("%s.ch%0d", name, i), e, a);
        end
    endtask

    task automatic check_cycles(string name, int exp, int act);
        if (act != exp) begin
            value_errs++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic protocol_error(string why);
        proto_errs++;
        $display("ERROR: %s", why);
    endtask

    task automatic abort_run(string why);
        protocol_error(why);
        abort = 1'b1;
    endtask

    // Records are C (ch offset gain), F (8 inputs, 8 expected, stall) and Q
    task automatic read_trace();
        int          fd;
        int          code;
        int          ch;
        int          stall;
        string       line;
        logic [15:0] off;
        logic [15:0] gn;
        logic [15:0] w [16];
        coeff_wr_t   c;
        fd = $fopen("cal_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open cal_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0) begin
                continue;
            end
            case (line.getc(0))
                "C": begin
                    code = $sscanf(line, "C %h %h %h", ch, off, gn);
                    c.ch     = chan_t'(ch);
                    c.offset = off;
                    c.gain   = gn;
                    cfg_list.push_back(c);
                    op_kind.push_back("C");
                end
                "F": begin
                    code = $sscanf(line,
                        "F %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7],
                        w[8], w[9], w[10], w[11], w[12], w[13], w[14], w[15], stall);
                    if (code != 17) begin
                        abort_run("malformed F record in the trace");
                    end
                    // Lane ch0 is the least significant word of a frame
                    in_list.push_back({w[7], w[6], w[5], w[4], w[3], w[2], w[1], w[0]});
                    exp_list.push_back({w[15], w[14], w[13], w[12],
                                        w[11], w[10], w[9], w[8]});
                    stall_list.push_back(stall);
                    op_kind.push_back("F");
                end
                "Q": op_kind.push_back("Q");
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    // All driver tasks start and end 2 ns after a rising edge
    task automatic send_cfg(coeff_wr_t c);
        int t;
        bit done;
        cfg       = c;
        cfg_valid = 1'b1;
        t    = 0;
        done = 1'b0;
        while (!done && !abort) begin
            @(posedge clk);
            if (cfg_ready) begin
                done = 1'b1;
            end else begin
                t++;
                if (t >= WAIT_LIMIT) abort_run("timed out waiting for cfg_ready");
            end
        end
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic send_frame(frame_t f, bit fresh);
        int t;
        bit done;
        in_frame = f;
        in_valid = 1'b1;
        t    = 0;
        done = 1'b0;
        while (!done && !abort) begin
            @(posedge clk);
            if (in_ready) begin
                done = 1'b1;
            end else begin
                t++;
                if (t >= WAIT_LIMIT) abort_run("timed out waiting for in_ready");
            end
        end
        if (done) begin
            acc_cyc.push_back(cyc);
            lat_chk.push_back(fresh);
            n_acc++;
            #1;
            // A captured frame must close the configuration port
            if (cfg_ready !== 1'b0) protocol_error("cfg_ready high while a frame is captured");
            #1;
        end else begin
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_empty();
        int t;
        t = 0;
        while (n_recv != n_acc && !abort) begin
            @(posedge clk);
            t++;
            if (t >= WAIT_LIMIT) abort_run("timed out waiting for the output to empty");
        end
        // Lets the sequencer settle back into IDLE
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic run_ops();
        int fi;
        int ci;
        int gap;
        bit fresh;
        fi    = 0;
        ci    = 0;
        fresh = 1'b1;
        foreach (op_kind[k]) begin
            if (abort) return;
            case (op_kind[k])
                "C": begin
                    send_cfg(cfg_list[ci]);
                    ci++;
                end
                "F": begin
                    gap = int'($urandom % 3);
                    if (gap > 0) begin
                        repeat (gap) @(posedge clk);
                        #2;
                    end
                    send_frame(in_list[fi], fresh);
                    fi++;
                    fresh = 1'b0;
                end
                default: begin
                    wait_empty();
                    fresh = 1'b1;
                end
            endcase
        end
    endtask

    task automatic run_monitor();
        int     t;
        int     stall;
        bit     seen;
        for (int idx = 0; idx < exp_list.size(); idx++) begin
            if (abort) return;
            stall     = stall_list[idx];
            out_ready = (stall == 0);
            t    = 0;
            seen = 1'b0;
            while (!seen && !abort) begin
                @(posedge clk);
                if (out_valid) begin
                    seen = 1'b1;
                end else begin
                    t++;
                    if (t >= WAIT_LIMIT) abort_run("timed out waiting for out_valid");
                end
            end
            if (!seen) return;
            // out_valid is first seen on the edge that closes its first high cycle
            if (lat_chk[idx]) begin
                check_cycles("out_valid latency", 13, cyc - acc_cyc[idx] - 1);
            end
            if (stall > 0) begin
                for (int s = 1; s < stall; s++) begin
                    @(posedge clk);
                    check_frame("out_frame held", exp_list[idx], out_frame);
                    if (!out_valid) protocol_error("out_valid dropped while out_ready was low");
                end
                #1;
                // The held output plus one captured frame must block the input
                if (n_acc >= n_recv + 2 && in_ready !== 1'b0) begin
                    protocol_error("in_ready high with the output stalled and a frame captured");
                end
                #1;
                out_ready = 1'b1;
                @(posedge clk);
            end
            check_frame("out_frame", exp_list[idx], out_frame);
            #1;
            n_recv++;
            #1;
            out_ready = 1'b0;
        end
    endtask

    initial begin
        rst        = 1'b1;
        in_frame   = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        cfg        = '0;
        cfg_valid  = 1'b0;
        n_acc      = 0;
        n_recv     = 0;
        value_errs = 0;
        proto_errs = 0;
        abort      = 1'b0;
        void'($urandom(32'h7c74_9784));
        read_trace();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        if (in_ready !== 1'b0 || out_valid !== 1'b0 || cfg_ready !== 1'b0) begin
            protocol_error("handshake outputs not low on the cycle after reset");
        end
        #1;
        fork
            run_ops();
            run_monitor();
        join
        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
